/* source/load_bus_pkg.sv */
`default_nettype none

package load_bus_pkg;

	// bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int ID_W = 4;

	// AXI read channel field types
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [ID_W-1:0] axi_id_t;
	typedef logic [3:0] len_t;
	typedef logic [2:0] size_t;
	typedef logic [1:0] burst_t;
	typedef logic [1:0] resp_t;

	// four bytes per beat
	localparam size_t SIZE_WORD = 3'b010;
	localparam burst_t BURST_INCR = 2'b01;
	localparam resp_t RESP_OKAY = 2'b00;

	// master index, doubles as the burst ID
	typedef enum logic
	{
		MASTER_DATA = 1'b0,
		MASTER_INST = 1'b1
	} master_e;

endpackage

`default_nettype wire

/* source/burst_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface burst_if;
	import load_bus_pkg::*;

	// a line request is owned and not yet released
	logic active;
	master_e owner;
	addr_t line_addr;
	// last beat of the burst has been taken
	logic done;

	modport arb
	(
		output active,
		output owner,
		output line_addr,
		input done
	);

	modport issue
	(
		input active,
		input owner,
		input line_addr
	);

	modport collect
	(
		input active,
		input owner,
		output done
	);

endinterface

`default_nettype wire

/* source/load_bus_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module load_bus_arbiter
(
	input logic clk,
	input logic rst_n_i,
	input logic dreq_i,
	input logic ireq_i,
	input load_bus_pkg::addr_t daddr_i,
	input load_bus_pkg::addr_t iaddr_i,
	output logic dgrnt_o,
	output logic igrnt_o,
	burst_if.arb bus
);
	import load_bus_pkg::*;

	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_OWNED,
		ST_CLOSING
	} state_e;

	state_e state;
	master_e owner;
	master_e pick;
	addr_t line_addr;
	logic grant_start;
	logic owner_req;

	// data side wins a tie
	always_comb
	begin
		if (dreq_i)
			pick = MASTER_DATA;
		else
			pick = MASTER_INST;
	end

	assign grant_start = (state == ST_IDLE) && (dreq_i || ireq_i);
	assign owner_req = (owner == MASTER_DATA) ? dreq_i : ireq_i;

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			state <= ST_IDLE;
			owner <= MASTER_DATA;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (grant_start)
					begin
						state <= ST_OWNED;
						owner <= pick;
					end
				end
				// burst in flight
				ST_OWNED:
				begin
					if (bus.done)
						state <= ST_CLOSING;
				end
				// hold the grant until the owner lets go of req
				ST_CLOSING:
				begin
					if (!owner_req)
						state <= ST_IDLE;
				end
				default:
				begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (grant_start)
			line_addr <= dreq_i ? daddr_i : iaddr_i;
	end

	assign bus.active = (state != ST_IDLE);
	assign bus.owner = owner;
	assign bus.line_addr = line_addr;

	assign dgrnt_o = bus.active && (owner == MASTER_DATA);
	assign igrnt_o = bus.active && (owner == MASTER_INST);

endmodule

`default_nettype wire

/* source/read_addr_issue.sv */
`timescale 1ns/10ps
`default_nettype none

module read_addr_issue
#(
	parameter int LINE_BEATS = 8
)
(
	input logic clk,
	input logic rst_n_i,
	burst_if.issue bus,
	output load_bus_pkg::axi_id_t arid_o,
	output load_bus_pkg::addr_t araddr_o,
	output load_bus_pkg::len_t arlen_o,
	output load_bus_pkg::size_t arsize_o,
	output load_bus_pkg::burst_t arburst_o,
	output logic arvalid_o,
	input logic arready_i
);
	import load_bus_pkg::*;

	localparam addr_t LINE_BYTES = addr_t'(LINE_BEATS * (DATA_W / 8));

	logic accepted;
	logic pending;

	// one burst per grant, gone once the slave takes it
	assign pending = bus.active && !accepted;

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			accepted <= 1'b0;
		else if (!bus.active)
			accepted <= 1'b0;
		else if (pending && arready_i)
			accepted <= 1'b1;
	end

	assign arvalid_o = pending;
	assign arid_o = axi_id_t'(bus.owner);
	// align down to the start of the line
	assign araddr_o = bus.line_addr - (bus.line_addr % LINE_BYTES);
	assign arlen_o = len_t'(LINE_BEATS - 1);
	assign arsize_o = SIZE_WORD;
	assign arburst_o = BURST_INCR;

endmodule

`default_nettype wire

/* source/read_data_collect.sv */
`timescale 1ns/10ps
`default_nettype none

module read_data_collect
#(
	parameter int LINE_BEATS = 8
)
(
	input logic clk,
	input logic rst_n_i,
	burst_if.collect bus,
	input load_bus_pkg::axi_id_t rid_i,
	input load_bus_pkg::data_t rdata_i,
	input load_bus_pkg::resp_t rresp_i,
	input logic rlast_i,
	input logic rvalid_i,
	output logic rready_o,
	output load_bus_pkg::data_t drdata_o,
	output load_bus_pkg::data_t irdata_o,
	output logic drvalid_o,
	output logic irvalid_o,
	output logic drlast_o,
	output logic irlast_o,
	output logic drerr_o,
	output logic irerr_o
);
	import load_bus_pkg::*;

	localparam int CNT_W = $clog2(LINE_BEATS);
	localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(LINE_BEATS - 1);

	logic [CNT_W-1:0] beat_cnt;
	logic finished;
	logic err_q;
	logic done_q;
	logic beat_fire;
	logic last_fire;
	logic beat_err;
	logic last_err;
	logic is_data;

	assign rready_o = bus.active && !finished;
	assign beat_fire = rvalid_i && rready_o;
	assign last_fire = beat_fire && rlast_i;
	assign is_data = (bus.owner == MASTER_DATA);

	// bad response, foreign ID, or rlast on the wrong beat
	assign beat_err = (rresp_i != RESP_OKAY)
		|| (rid_i != axi_id_t'(bus.owner))
		|| (rlast_i != (beat_cnt == LAST_BEAT));
	assign last_err = err_q || beat_err;

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			beat_cnt <= '0;
			finished <= 1'b0;
			err_q <= 1'b0;
		end
		else if (!bus.active)
		begin
			beat_cnt <= '0;
			finished <= 1'b0;
			err_q <= 1'b0;
		end
		else if (beat_fire)
		begin
			beat_cnt <= beat_cnt + 1'b1;
			err_q <= last_err;
			if (rlast_i)
				finished <= 1'b1;
		end
	end

	// one-cycle pulse after the last beat
	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			done_q <= 1'b0;
		else
			done_q <= last_fire;
	end

	assign bus.done = done_q;

	// steer the beat to whoever owns the bus
	assign drdata_o = is_data ? rdata_i : '0;
	assign irdata_o = is_data ? '0 : rdata_i;
	assign drvalid_o = beat_fire && is_data;
	assign irvalid_o = beat_fire && !is_data;
	assign drlast_o = last_fire && is_data;
	assign irlast_o = last_fire && !is_data;
	assign drerr_o = last_fire && is_data && last_err;
	assign irerr_o = last_fire && !is_data && last_err;

endmodule

`default_nettype wire

/* source/mips_load_bus.sv */
`timescale 1ns/10ps
`default_nettype none

module mips_load_bus
#(
	parameter int LINE_BEATS = 8
)
(
	input logic clk,
	input logic rst_n_i,

	// data cache side
	input logic dmst_req_i,
	input load_bus_pkg::addr_t dmst_addr_i,
	output logic dmst_grnt_o,
	output load_bus_pkg::data_t dmst_rdata_o,
	output logic dmst_rvalid_o,
	output logic dmst_rlast_o,
	output logic dmst_rerr_o,

	// instruction cache side
	input logic imst_req_i,
	input load_bus_pkg::addr_t imst_addr_i,
	output logic imst_grnt_o,
	output load_bus_pkg::data_t imst_rdata_o,
	output logic imst_rvalid_o,
	output logic imst_rlast_o,
	output logic imst_rerr_o,

	// read address channel
	output load_bus_pkg::axi_id_t arid_o,
	output load_bus_pkg::addr_t araddr_o,
	output load_bus_pkg::len_t arlen_o,
	output load_bus_pkg::size_t arsize_o,
	output load_bus_pkg::burst_t arburst_o,
	output logic arvalid_o,
	input logic arready_i,

	// read data channel
	input load_bus_pkg::axi_id_t rid_i,
	input load_bus_pkg::data_t rdata_i,
	input load_bus_pkg::resp_t rresp_i,
	input logic rlast_i,
	input logic rvalid_i,
	output logic rready_o
);

	burst_if bus_if ();

	load_bus_arbiter u_arbiter
	(
		.clk(clk),
		.rst_n_i(rst_n_i),
		.dreq_i(dmst_req_i),
		.ireq_i(imst_req_i),
		.daddr_i(dmst_addr_i),
		.iaddr_i(imst_addr_i),
		.dgrnt_o(dmst_grnt_o),
		.igrnt_o(imst_grnt_o),
		.bus(bus_if.arb)
	);

	read_addr_issue
	#(
		.LINE_BEATS(LINE_BEATS)
	)
	u_addr_issue
	(
		.clk(clk),
		.rst_n_i(rst_n_i),
		.bus(bus_if.issue),
		.arid_o(arid_o),
		.araddr_o(araddr_o),
		.arlen_o(arlen_o),
		.arsize_o(arsize_o),
		.arburst_o(arburst_o),
		.arvalid_o(arvalid_o),
		.arready_i(arready_i)
	);

	read_data_collect
	#(
		.LINE_BEATS(LINE_BEATS)
	)
	u_data_collect
	(
		.clk(clk),
		.rst_n_i(rst_n_i),
		.bus(bus_if.collect),
		.rid_i(rid_i),
		.rdata_i(rdata_i),
		.rresp_i(rresp_i),
		.rlast_i(rlast_i),
		.rvalid_i(rvalid_i),
		.rready_o(rready_o),
		.drdata_o(dmst_rdata_o),
		.irdata_o(imst_rdata_o),
		.drvalid_o(dmst_rvalid_o),
		.irvalid_o(imst_rvalid_o),
		.drlast_o(dmst_rlast_o),
		.irlast_o(imst_rlast_o),
		.drerr_o(dmst_rerr_o),
		.irerr_o(imst_rerr_o)
	);

endmodule

`default_nettype wire

/* tests/load_bus_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module load_bus_assertions
(
	input logic clk,
	input logic rst_n_i,
	input logic dreq_i,
	input logic ireq_i,
	input logic dgrnt_i,
	input logic igrnt_i,
	input load_bus_pkg::axi_id_t arid_i,
	input load_bus_pkg::addr_t araddr_i,
	input load_bus_pkg::len_t arlen_i,
	input load_bus_pkg::size_t arsize_i,
	input load_bus_pkg::burst_t arburst_i,
	input logic arvalid_i,
	input logic arready_i
);

	// AR request held steady until the slave takes it
	property ar_held;
		@(posedge clk) disable iff (!rst_n_i)
		(arvalid_i && !arready_i) |=> (arvalid_i && $stable(arid_i) && $stable(araddr_i)
			&& $stable(arlen_i) && $stable(arsize_i) && $stable(arburst_i));
	endproperty

	a_ar_held: assert property (ar_held)
		else $error("read address request changed before it was accepted");

	// no overlap, and the bus sits idle a cycle before changing hands
	a_grant_mutex: assert property (@(posedge clk) disable iff (!rst_n_i)
		!(dgrnt_i && igrnt_i) && !($fell(dgrnt_i) && igrnt_i)
			&& !($fell(igrnt_i) && dgrnt_i))
		else $error("grants overlap or change hands without an idle cycle");

	a_dgrnt_req: assert property (@(posedge clk) disable iff (!rst_n_i)
		$rose(dgrnt_i) |-> $past(dreq_i))
		else $error("data grant rose without a request");

	a_igrnt_req: assert property (@(posedge clk) disable iff (!rst_n_i)
		$rose(igrnt_i) |-> $past(ireq_i))
		else $error("instruction grant rose without a request");

endmodule

bind mips_load_bus load_bus_assertions u_assertions
(
	.clk(clk),
	.rst_n_i(rst_n_i),
	.dreq_i(dmst_req_i),
	.ireq_i(imst_req_i),
	.dgrnt_i(dmst_grnt_o),
	.igrnt_i(imst_grnt_o),
	.arid_i(arid_o),
	.araddr_i(araddr_o),
	.arlen_i(arlen_o),
	.arsize_i(arsize_o),
	.arburst_i(arburst_o),
	.arvalid_i(arvalid_o),
	.arready_i(arready_i)
);

`default_nettype wire

/* tests/tb_mips_load_bus.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mips_load_bus;
	import load_bus_pkg::*;

	// same as the top-level default
	localparam int LINE_BEATS = 8;
	localparam int WAIT_LIMIT = 400;

	logic clk = 1'b0;
	logic rst_n_i;
	logic dmst_req_i;
	addr_t dmst_addr_i;
	logic dmst_grnt_o;
	data_t dmst_rdata_o;
	logic dmst_rvalid_o;
	logic dmst_rlast_o;
	logic dmst_rerr_o;
	logic imst_req_i;
	addr_t imst_addr_i;
	logic imst_grnt_o;
	data_t imst_rdata_o;
	logic imst_rvalid_o;
	logic imst_rlast_o;
	logic imst_rerr_o;
	axi_id_t arid_o;
	addr_t araddr_o;
	len_t arlen_o;
	size_t arsize_o;
	burst_t arburst_o;
	logic arvalid_o;
	logic arready_i;
	axi_id_t rid_i;
	data_t rdata_i;
	resp_t rresp_i;
	logic rlast_i;
	logic rvalid_i;
	logic rready_o;

	// slave model knobs and the last AR it took
	int max_ar_wait = 3;
	int max_gap = 2;
	int err_beat = -1;
	axi_id_t ar_id;
	addr_t ar_addr;
	len_t ar_len;
	size_t ar_size;
	burst_t ar_burst;

	mips_load_bus uut (.*);

	always #20 clk = ~clk;

	task automatic next_cycle();
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic fail_run(input string why);
		begin
			$display("SOME TESTS FAILED");
			$fatal(1, "run stopped: %s", why);
		end
	endtask

	task automatic timeout_fail(input string what);
		begin
			$display("Error at %0t: timed out waiting for %s", $time, what);
			fail_run("timeout");
		end
	endtask

	task automatic check_addr(input addr_t got, input addr_t exp, input string what);
		begin
			if (got !== exp)
			begin
				$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
				fail_run("address compare");
			end
		end
	endtask

	task automatic check_data(input data_t got, input data_t exp, input string what);
		begin
			if (got !== exp)
			begin
				$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
				fail_run("data compare");
			end
		end
	endtask

	task automatic check_id(input axi_id_t got, input axi_id_t exp, input string what);
		begin
			if (got !== exp)
			begin
				$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
				fail_run("ID compare");
			end
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		begin
			if (got !== exp)
			begin
				$display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
				fail_run("flag compare");
			end
		end
	endtask

	// beat k of a line: address of the word XOR a tag carrying the ID
	function automatic data_t model_word(input addr_t base, input axi_id_t id, input int k);
		begin
			return data_t'(base + addr_t'(4 * k)) ^ (32'hc0de0000 + data_t'(id));
		end
	endfunction

	// slave side of the read channels
	initial
	begin : slave_model
		int pause;
		arready_i = 1'b0;
		rvalid_i = 1'b0;
		rlast_i = 1'b0;
		rid_i = '0;
		rdata_i = '0;
		rresp_i = RESP_OKAY;
		forever
		begin
			@(negedge clk);
			if (arvalid_o)
			begin
				ar_id = arid_o;
				ar_addr = araddr_o;
				ar_len = arlen_o;
				ar_size = arsize_o;
				ar_burst = arburst_o;
				pause = $urandom_range(max_ar_wait, 0);
				repeat (pause + 1) next_cycle();
				arready_i = 1'b1;
				next_cycle();
				arready_i = 1'b0;
				for (int k = 0; k < LINE_BEATS; k++)
				begin
					pause = $urandom_range(max_gap, 0);
					repeat (pause) next_cycle();
					rvalid_i = 1'b1;
					rid_i = ar_id;
					rdata_i = model_word(ar_addr, ar_id, k);
					// SLVERR on the chosen beat
					rresp_i = (k == err_beat) ? resp_t'(2'b10) : RESP_OKAY;
					rlast_i = (k == LINE_BEATS - 1);
					@(negedge clk);
					check_bit(rready_o, 1'b1, "rready_o while a beat is offered");
					next_cycle();
					rvalid_i = 1'b0;
					rlast_i = 1'b0;
				end
			end
		end
	end

	task automatic drive_req(input master_e m, input logic req, input addr_t addr);
		begin
			if (m == MASTER_DATA)
			begin
				dmst_req_i = req;
				dmst_addr_i = addr;
			end
			else
			begin
				imst_req_i = req;
				imst_addr_i = addr;
			end
		end
	endtask

	task automatic read_master(input master_e m, output logic grnt, output logic valid,
		output data_t data, output logic last, output logic err, output logic other_valid);
		begin
			if (m == MASTER_DATA)
			begin
				grnt = dmst_grnt_o;
				valid = dmst_rvalid_o;
				data = dmst_rdata_o;
				last = dmst_rlast_o;
				err = dmst_rerr_o;
				other_valid = imst_rvalid_o;
			end
			else
			begin
				grnt = imst_grnt_o;
				valid = imst_rvalid_o;
				data = imst_rdata_o;
				last = imst_rlast_o;
				err = imst_rerr_o;
				other_valid = dmst_rvalid_o;
			end
		end
	endtask

	// one line refill from a master through the full req/grnt handshake
	task automatic refill(input master_e m, input addr_t addr, input logic exp_err);
		addr_t base;
		axi_id_t id;
		int beats;
		int cycles;
		logic grnt;
		logic valid;
		logic last;
		logic err;
		logic other_valid;
		data_t data;
		begin
			base = (addr / addr_t'(LINE_BEATS * 4)) * addr_t'(LINE_BEATS * 4);
			id = axi_id_t'(m);
			next_cycle();
			drive_req(m, 1'b1, addr);
			cycles = 0;
			grnt = 1'b0;
			while (!grnt)
			begin
				@(negedge clk);
				read_master(m, grnt, valid, data, last, err, other_valid);
				cycles++;
				if (cycles > WAIT_LIMIT)
					timeout_fail("grant");
			end
			beats = 0;
			cycles = 0;
			last = 1'b0;
			while (!last)
			begin
				@(negedge clk);
				read_master(m, grnt, valid, data, last, err, other_valid);
				check_bit(grnt, 1'b1, "grant during burst");
				check_bit(other_valid, 1'b0, "rvalid of the other master");
				if (valid)
				begin
					check_data(data, model_word(base, id, beats), "beat data");
					check_bit(last, beats == LINE_BEATS - 1, "rlast");
					check_bit(err, (beats == LINE_BEATS - 1) && exp_err, "rerr");
					beats++;
				end
				cycles++;
				if (cycles > WAIT_LIMIT)
					timeout_fail("last beat");
			end
			check_bit(beats == LINE_BEATS, 1'b1, "beats per grant");
			check_id(ar_id, id, "arid");
			check_addr(ar_addr, base, "araddr");
			check_bit(ar_len == len_t'(LINE_BEATS - 1), 1'b1, "arlen is beats minus one");
			check_bit(ar_size == SIZE_WORD, 1'b1, "arsize is word");
			check_bit(ar_burst == BURST_INCR, 1'b1, "arburst is incrementing");
			// release, then wait for the grant to fall
			next_cycle();
			drive_req(m, 1'b0, addr);
			cycles = 0;
			while (grnt)
			begin
				@(negedge clk);
				read_master(m, grnt, valid, data, last, err, other_valid);
				check_bit(valid, 1'b0, "rvalid after last beat");
				check_bit(rready_o, 1'b0, "rready after last beat");
				check_bit(arvalid_o, 1'b0, "arvalid after last beat");
				cycles++;
				if (cycles > WAIT_LIMIT)
					timeout_fail("grant release");
			end
		end
	endtask

	task automatic check_idle(input string when);
		begin
			check_bit(dmst_grnt_o, 1'b0, {"dmst_grnt_o ", when});
			check_bit(imst_grnt_o, 1'b0, {"imst_grnt_o ", when});
			check_bit(arvalid_o, 1'b0, {"arvalid_o ", when});
			check_bit(rready_o, 1'b0, {"rready_o ", when});
			check_bit(dmst_rvalid_o, 1'b0, {"dmst_rvalid_o ", when});
			check_bit(imst_rvalid_o, 1'b0, {"imst_rvalid_o ", when});
			check_bit(dmst_rlast_o, 1'b0, {"dmst_rlast_o ", when});
			check_bit(imst_rlast_o, 1'b0, {"imst_rlast_o ", when});
			check_bit(dmst_rerr_o, 1'b0, {"dmst_rerr_o ", when});
			check_bit(imst_rerr_o, 1'b0, {"imst_rerr_o ", when});
		end
	endtask

	task automatic test_reset();
		begin
			rst_n_i = 1'b0;
			repeat (10)
			begin
				@(negedge clk);
				check_idle("during reset");
			end
			next_cycle();
			rst_n_i = 1'b1;
			repeat (2)
			begin
				@(negedge clk);
				check_idle("after reset");
			end
		end
	endtask

	task automatic test_data_refill();
		begin
			refill(MASTER_DATA, 32'h0000_1234, 1'b0);
		end
	endtask

	task automatic test_inst_refill();
		begin
			refill(MASTER_INST, 32'h8000_0f3c, 1'b0);
		end
	endtask

	// instruction grant may only show up once the data side has let go
	task automatic watch_grant_order();
		int cycles;
		logic data_seen;
		begin
			cycles = 0;
			data_seen = 1'b0;
			while (!imst_grnt_o)
			begin
				@(negedge clk);
				if (dmst_grnt_o)
					data_seen = 1'b1;
				cycles++;
				if (cycles > 2 * WAIT_LIMIT)
					timeout_fail("instruction grant");
			end
			check_bit(data_seen, 1'b1, "data master granted first");
			check_bit(dmst_req_i, 1'b0, "data req low at instruction grant");
			check_bit(dmst_grnt_o, 1'b0, "data grant low at instruction grant");
		end
	endtask

	task automatic test_arbitration();
		begin
			fork
				refill(MASTER_DATA, 32'h1000_0008, 1'b0);
				refill(MASTER_INST, 32'h2000_0014, 1'b0);
				watch_grant_order();
			join
		end
	endtask

	task automatic test_error_response();
		begin
			err_beat = LINE_BEATS / 2;
			refill(MASTER_DATA, 32'h0040_0104, 1'b1);
			err_beat = -1;
			refill(MASTER_DATA, 32'h0040_0140, 1'b0);
		end
	endtask

	task automatic test_back_pressure();
		addr_t addr;
		begin
			max_ar_wait = 12;
			max_gap = 6;
			for (int n = 0; n < 6; n++)
			begin
				addr = addr_t'($urandom);
				refill((n % 2 == 0) ? MASTER_DATA : MASTER_INST, addr, 1'b0);
			end
			max_ar_wait = 3;
			max_gap = 2;
		end
	endtask

	initial
	begin
		void'($urandom(32'h5bc8));
		rst_n_i = 1'b0;
		dmst_req_i = 1'b0;
		dmst_addr_i = '0;
		imst_req_i = 1'b0;
		imst_addr_i = '0;
		test_reset();
		test_data_refill();
		test_inst_refill();
		test_arbitration();
		test_error_response();
		test_back_pressure();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
source/load_bus_pkg.sv
source/burst_if.sv
source/load_bus_arbiter.sv
source/read_addr_issue.sv
source/read_data_collect.sv
source/mips_load_bus.sv
tests/load_bus_assertions.sv
tests/tb_mips_load_bus.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_mips_load_bus -f compile.f -o sim_tb
./obj_dir/sim_tb
